//--- flist.f
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/reg_file.sv
source/instr_decode.sv
source/id_ex_reg.sv
source/execute_unit.sv
source/cpu_core_top.sv
verif/cpu_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module cpu_core_tb \
  --Mdir obj_dir \
  -o cpu_core_sim

./obj_dir/cpu_core_sim

//--- verif/cpu_core_tb.sv
// Testbench with clock, reset, program stimulus, Wishbone memory, reference model and checks
`timescale 1ns/1ps

module cpu_core_tb;

  typedef struct packed {
    logic               we;
    cpu_isa_pkg::word_t adr;
    cpu_isa_pkg::word_t data;
  } bus_op_t;

  logic                  clk;
  logic                  rst;
  logic                  instr_valid;
  cpu_isa_pkg::instr_u   instr;
  logic                  instr_ready;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  cpu_isa_pkg::word_t    wb_adr;
  cpu_isa_pkg::word_t    wb_dat_o;
  cpu_isa_pkg::word_t    wb_dat_i = '0;
  logic                  wb_ack = 1'b0;
  cpu_pipe_pkg::commit_t commit;
  logic                  halted;

  cpu_isa_pkg::instr_u   prog[$];
  cpu_isa_pkg::instr_u   extra_word;
  cpu_pipe_pkg::commit_t exp_commits[$];
  bus_op_t               exp_bus[$];
  cpu_pipe_pkg::commit_t exp_c;
  bus_op_t               exp_b;
  cpu_isa_pkg::word_t    ref_regs [16];
  cpu_isa_pkg::word_t    ref_mem [256];
  cpu_isa_pkg::word_t    mem [256];
  logic [1:0]            ack_delays [64];
  logic [5:0]            bus_op_cnt = '0;
  logic [1:0]            wait_cnt = '0;
  logic [31:0]           seed;
  logic [31:0]           rnd;
  int                    n_accepted = 0;
  int                    cycle_cnt = 0;
  int                    cycle_limit = 0;

  cpu_core_top uut (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_o    (wb_dat_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack      (wb_ack),
    .commit      (commit),
    .halted      (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic cpu_isa_pkg::instr_u r_word(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [3:0] rs, input logic [3:0] rt);
    cpu_isa_pkg::instr_u w;
    w.r_fmt.opcode = cpu_isa_pkg::opcode_e'(op);
    w.r_fmt.rd     = rd;
    w.r_fmt.rs     = rs;
    w.r_fmt.rt     = rt;
    return w;
  endfunction

  function automatic cpu_isa_pkg::instr_u i_word(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [7:0] imm);
    cpu_isa_pkg::instr_u w;
    w.i_fmt.opcode = cpu_isa_pkg::opcode_e'(op);
    w.i_fmt.rd     = rd;
    w.i_fmt.imm    = imm;
    return w;
  endfunction

  // Every address bit shows up in the word
  function automatic cpu_isa_pkg::word_t fill_word(input logic [7:0] a);
    return {a ^ 8'h5c, ~a};
  endfunction

  // Register and memory model stepped once per accepted word
  function automatic void step_model(input cpu_isa_pkg::instr_u w);
    cpu_isa_pkg::word_t a;
    cpu_isa_pkg::word_t b;
    cpu_isa_pkg::word_t old;
    cpu_isa_pkg::word_t adr;
    cpu_isa_pkg::word_t res;
    logic               wr;
    a   = ref_regs[w.r_fmt.rs];
    b   = ref_regs[w.r_fmt.rt];
    old = ref_regs[w.r_fmt.rd];
    adr = a + {{12{w.r_fmt.rt[3]}}, w.r_fmt.rt};
    res = '0;
    wr  = 1'b1;
    case (w.r_fmt.opcode)
      cpu_isa_pkg::OP_ADD: res = a + b;
      cpu_isa_pkg::OP_SUB: res = a - b;
      cpu_isa_pkg::OP_AND: res = a & b;
      cpu_isa_pkg::OP_XOR: res = a ^ b;
      cpu_isa_pkg::OP_SLL: res = a << b[3:0];
      cpu_isa_pkg::OP_SRL: res = a >> b[3:0];
      cpu_isa_pkg::OP_LLB: res = {old[15:8], w.i_fmt.imm};
      cpu_isa_pkg::OP_LHB: res = {w.i_fmt.imm, old[7:0]};
      cpu_isa_pkg::OP_LW: begin
        res = ref_mem[adr[7:0]];
        exp_bus.push_back(bus_op_t'{we: 1'b0, adr: adr, data: 16'h0000});
      end
      cpu_isa_pkg::OP_SW: begin
        wr = 1'b0;
        ref_mem[adr[7:0]] = old;
        exp_bus.push_back(bus_op_t'{we: 1'b1, adr: adr, data: old});
      end
      default: wr = 1'b0;
    endcase
    if (wr) begin
      exp_commits.push_back(cpu_pipe_pkg::commit_t'{valid: 1'b1, rd: w.r_fmt.rd, data: res});
      if (w.r_fmt.rd != 4'd0) begin
        ref_regs[w.r_fmt.rd] = res;
      end
    end
  endfunction

  task automatic build_program();
    prog.push_back(i_word(cpu_isa_pkg::OP_LLB, 4'd1, 8'h34));
    prog.push_back(i_word(cpu_isa_pkg::OP_LHB, 4'd1, 8'h12));
    prog.push_back(i_word(cpu_isa_pkg::OP_LLB, 4'd2, 8'h03));
    // Dependent ALU chain through the bypass
    prog.push_back(r_word(cpu_isa_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
    prog.push_back(r_word(cpu_isa_pkg::OP_SUB, 4'd4, 4'd3, 4'd1));
    prog.push_back(r_word(cpu_isa_pkg::OP_AND, 4'd5, 4'd3, 4'd4));
    prog.push_back(r_word(cpu_isa_pkg::OP_XOR, 4'd6, 4'd3, 4'd5));
    prog.push_back(r_word(cpu_isa_pkg::OP_SLL, 4'd7, 4'd3, 4'd2));
    prog.push_back(r_word(cpu_isa_pkg::OP_SRL, 4'd8, 4'd7, 4'd4));
    prog.push_back(r_word(cpu_isa_pkg::OP_SUB, 4'd9, 4'd2, 4'd1));
    prog.push_back(r_word(4'd6, 4'd10, 4'd1, 4'd1));
    prog.push_back(i_word(cpu_isa_pkg::OP_LLB, 4'd10, 8'h40));
    // Stores and loads around base 0x40
    prog.push_back(r_word(cpu_isa_pkg::OP_SW, 4'd3, 4'd10, 4'd5));
    prog.push_back(r_word(cpu_isa_pkg::OP_SW, 4'd9, 4'd10, 4'hd));
    prog.push_back(r_word(cpu_isa_pkg::OP_LW, 4'd11, 4'd10, 4'd5));
    prog.push_back(r_word(cpu_isa_pkg::OP_LW, 4'd12, 4'd10, 4'hd));
    prog.push_back(r_word(cpu_isa_pkg::OP_LW, 4'd13, 4'd10, 4'd7));
    prog.push_back(r_word(cpu_isa_pkg::OP_ADD, 4'd14, 4'd11, 4'd12));
    prog.push_back(r_word(cpu_isa_pkg::OP_SW, 4'd14, 4'd10, 4'h8));
    prog.push_back(r_word(cpu_isa_pkg::OP_LW, 4'd15, 4'd10, 4'h8));
    prog.push_back(r_word(cpu_isa_pkg::OP_ADD, 4'd0, 4'd1, 4'd1));
    prog.push_back(r_word(cpu_isa_pkg::OP_ADD, 4'd5, 4'd0, 4'd1));
    for (int k = 0; k < 24; k++) begin
      rnd = $random(seed);
      case (rnd[18:16])
        3'd6:    prog.push_back(i_word(cpu_isa_pkg::OP_LLB, rnd[3:0], rnd[11:4]));
        3'd7:    prog.push_back(i_word(cpu_isa_pkg::OP_LHB, rnd[3:0], rnd[11:4]));
        default: prog.push_back(r_word({1'b0, rnd[18:16]}, rnd[3:0], rnd[7:4], rnd[11:8]));
      endcase
    end
    prog.push_back(r_word(cpu_isa_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
    for (int k = 0; k < 64; k++) begin
      rnd = $random(seed);
      ack_delays[k[5:0]] = rnd[1:0];
    end
  endtask

  // Wishbone slave with 0 to 3 wait cycles per access
  always @(negedge clk) begin
    if (wb_cyc && wb_stb && !wb_ack) begin
      if (wait_cnt == ack_delays[bus_op_cnt]) begin
        wb_ack   = 1'b1;
        wb_dat_i = mem[wb_adr[7:0]];
        if (wb_we) begin
          mem[wb_adr[7:0]] = wb_dat_o;
        end
        bus_op_cnt = bus_op_cnt + 6'd1;
      end else begin
        wait_cnt = wait_cnt + 2'd1;
      end
    end else begin
      wb_ack   = 1'b0;
      wait_cnt = 2'd0;
    end
  end

  // Commits and bus cycles are checked before the word accepted on this edge
  always @(posedge clk) begin
    if (!rst) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        stop_run($sformatf("Timeout: simulation did not halt after %0d cycles", cycle_cnt));
      end
      if (commit.valid) begin
        assert (exp_commits.size() != 0)
          else stop_run($sformatf("Mismatch at %0t: unexpected commit to r%0d", $time, commit.rd));
        exp_c = exp_commits.pop_front();
        assert (commit.rd == exp_c.rd && commit.data == exp_c.data)
          else stop_run($sformatf("Mismatch at %0t: commit r%0d=%h, expected r%0d=%h",
                                  $time, commit.rd, commit.data, exp_c.rd, exp_c.data));
      end
      if (wb_cyc && wb_stb && wb_ack) begin
        assert (exp_bus.size() != 0)
          else stop_run($sformatf("Mismatch at %0t: unexpected bus access", $time));
        exp_b = exp_bus.pop_front();
        assert (wb_we == exp_b.we && wb_adr == exp_b.adr && (!wb_we || wb_dat_o == exp_b.data))
          else stop_run($sformatf("Mismatch at %0t: bus we=%b adr=%h dat=%h, expected %b %h %h",
                                  $time, wb_we, wb_adr, wb_dat_o, exp_b.we, exp_b.adr,
                                  exp_b.data));
      end
      if (instr_valid && instr_ready) begin
        assert (n_accepted < prog.size())
          else stop_run("Instruction stream accepted a word after HLT");
        step_model(instr);
        n_accepted++;
      end
    end
  end

  bus_held_until_ack: assert property (
    @(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)
  ) else stop_run($sformatf("Mismatch at %0t: Wishbone request changed before ack", $time));

  stream_blocked_on_bus: assert property (
    @(posedge clk) disable iff (rst)
    wb_cyc && !wb_ack |-> !instr_ready
  ) else stop_run($sformatf("Mismatch at %0t: instr_ready high during bus wait", $time));

  halt_sticky: assert property (
    @(posedge clk) disable iff (rst)
    halted |=> halted
  ) else stop_run($sformatf("Mismatch at %0t: halted dropped", $time));

  halt_quiet: assert property (
    @(posedge clk) disable iff (rst)
    halted |-> !instr_ready && !commit.valid
  ) else stop_run($sformatf("Mismatch at %0t: activity after halt", $time));

  initial begin
    seed        = 32'h8c94;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (int k = 0; k < 256; k++) begin
      mem[k[7:0]]     = fill_word(k[7:0]);
      ref_mem[k[7:0]] = fill_word(k[7:0]);
    end
    for (int k = 0; k < 16; k++) begin
      ref_regs[k[3:0]] = '0;
    end
    build_program();
    cycle_limit = 40 * prog.size();
    extra_word  = r_word(cpu_isa_pkg::OP_ADD, 4'd1, 4'd1, 4'd1);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!wb_cyc && !wb_stb && !commit.valid && !halted && instr_ready)
      else stop_run($sformatf("Mismatch at %0t: outputs not idle after reset", $time));
    // Word stays put until accepted, then a stray word is offered after HLT
    while (!halted) begin
      instr_valid = 1'b1;
      instr       = (n_accepted < prog.size()) ? prog[n_accepted] : extra_word;
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    if (exp_commits.size() == 0 && exp_bus.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_run($sformatf("Mismatch at %0t: %0d commits and %0d bus cycles never seen",
                         $time, exp_commits.size(), exp_bus.size()));
    end
  end

endmodule

//--- source/cpu_core_top.sv
// Core top: decode, register file, ID/EX register and execute wired together
`timescale 1ns/1ps

module cpu_core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  cpu_isa_pkg::instr_u   instr,
  output logic                  instr_ready,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output cpu_isa_pkg::word_t    wb_adr,
  output cpu_isa_pkg::word_t    wb_dat_o,
  input  cpu_isa_pkg::word_t    wb_dat_i,
  input  logic                  wb_ack,
  output cpu_pipe_pkg::commit_t commit,
  output logic                  halted
);

  cpu_isa_pkg::reg_idx_t rs_idx;
  cpu_isa_pkg::reg_idx_t rt_idx;
  cpu_isa_pkg::word_t    rs_val;
  cpu_isa_pkg::word_t    rt_val;
  cpu_pipe_pkg::id_ex_t  id_rec;
  cpu_pipe_pkg::id_ex_t  ex_rec;
  logic                  stall_n;

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .rs_idx (rs_idx),
    .rt_idx (rt_idx),
    .rs_val (rs_val),
    .rt_val (rt_val),
    .wr     (commit)
  );

  instr_decode u_instr_decode (
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .stall_n     (stall_n),
    .rs_idx      (rs_idx),
    .rt_idx      (rt_idx),
    .rs_val      (rs_val),
    .rt_val      (rt_val),
    .id_rec      (id_rec)
  );

  id_ex_reg u_id_ex_reg (
    .clk     (clk),
    .rst     (rst),
    .stall_n (stall_n),
    .id_rec  (id_rec),
    .ex_rec  (ex_rec)
  );

  // Writeback commit feeds the register file write port and the trace output
  execute_unit u_execute_unit (
    .clk      (clk),
    .rst      (rst),
    .ex_rec   (ex_rec),
    .stall_n  (stall_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .commit   (commit),
    .halted   (halted)
  );

endmodule

//--- source/execute_unit.sv
// Execute stage with ALU, load-half merge, Wishbone classic access, halt latch and commit
`timescale 1ns/1ps

module execute_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_pipe_pkg::id_ex_t  ex_rec,
  output logic                  stall_n,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output cpu_isa_pkg::word_t    wb_adr,
  output cpu_isa_pkg::word_t    wb_dat_o,
  input  cpu_isa_pkg::word_t    wb_dat_i,
  input  logic                  wb_ack,
  output cpu_pipe_pkg::commit_t commit,
  output logic                  halted
);

  cpu_isa_pkg::word_t alu_res;
  logic               mem_req;
  logic               hlt_req;
  logic               bus_done;
  logic               busy;
  logic               turnaround;

  // Bus stays idle for one cycle after every ack
  assign mem_req  = ex_rec.valid && (ex_rec.mem_read || ex_rec.mem_write) && !halted;
  assign hlt_req  = ex_rec.valid && ex_rec.halt;
  assign wb_cyc   = mem_req && !turnaround;
  assign wb_stb   = wb_cyc;
  assign wb_we    = ex_rec.mem_write;
  assign wb_adr   = ex_rec.rs_data + ex_rec.imm;
  assign wb_dat_o = ex_rec.rt_data;
  assign bus_done = wb_cyc && wb_ack;

  // HLT also blocks the stream in its own execute cycle
  assign stall_n = !halted && !hlt_req && !(mem_req && !bus_done);

  always_comb begin
    case (ex_rec.opcode)
      cpu_isa_pkg::OP_ADD: alu_res = ex_rec.rs_data + ex_rec.rt_data;
      cpu_isa_pkg::OP_SUB: alu_res = ex_rec.rs_data - ex_rec.rt_data;
      cpu_isa_pkg::OP_AND: alu_res = ex_rec.rs_data & ex_rec.rt_data;
      cpu_isa_pkg::OP_XOR: alu_res = ex_rec.rs_data ^ ex_rec.rt_data;
      cpu_isa_pkg::OP_SLL: alu_res = ex_rec.rs_data << ex_rec.rt_data[3:0];
      cpu_isa_pkg::OP_SRL: alu_res = ex_rec.rs_data >> ex_rec.rt_data[3:0];
      // rt_data carries the old rd value here
      cpu_isa_pkg::OP_LLB: alu_res = {ex_rec.rt_data[15:8], ex_rec.imm[7:0]};
      cpu_isa_pkg::OP_LHB: alu_res = {ex_rec.imm[7:0], ex_rec.rt_data[7:0]};
      default:             alu_res = '0;
    endcase
  end

  // Loads commit only in the ack cycle
  always_comb begin
    commit.valid = ex_rec.valid && ex_rec.reg_write &&
                   (!ex_rec.mem_read || bus_done);
    commit.rd    = ex_rec.rd;
    commit.data  = ex_rec.mem_read ? wb_dat_i : alu_res;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      turnaround <= 1'b0;
      halted     <= 1'b0;
    end else begin
      busy       <= wb_cyc && !wb_ack;
      turnaround <= bus_done;
      halted     <= halted || hlt_req;
    end
  end

  // One access per bus cycle so the bus drops right after ack
  wb_cycle_ends_after_ack: assert property (
    @(posedge clk) disable iff (rst)
    wb_stb && wb_ack |=> !wb_cyc && !wb_stb
  );

  // An open cycle keeps strobe and every request field until ack
  wb_request_held: assert property (
    @(posedge clk) disable iff (rst)
    busy |-> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)
  );

  no_commit_after_halt: assert property (
    @(posedge clk) disable iff (rst)
    halted |-> !commit.valid
  );

endmodule

//--- source/id_ex_reg.sv
// ID/EX pipeline register that loads on stall_n, holds during a stall and clears on reset
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall_n,
  input  cpu_pipe_pkg::id_ex_t id_rec,
  output cpu_pipe_pkg::id_ex_t ex_rec
);

  // Reset clears the whole record so a stale opcode never reaches execute
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_rec <= cpu_pipe_pkg::ID_EX_NOP;
    end else if (stall_n) begin
      ex_rec <= id_rec;
    end
  end

  // Execute stalls only on a live record and needs it unchanged for the whole bus wait
  ex_rec_hold_during_stall: assert property (
    @(posedge clk) disable iff (rst)
    !stall_n |=> $stable(ex_rec) && ex_rec.valid
  );

endmodule

//--- source/instr_decode.sv
// Decode stage with stream handshake, format split, register read selection and ID/EX record
`timescale 1ns/1ps

module instr_decode (
  input  logic                  instr_valid,
  input  cpu_isa_pkg::instr_u   instr,
  output logic                  instr_ready,
  input  logic                  stall_n,
  output cpu_isa_pkg::reg_idx_t rs_idx,
  output cpu_isa_pkg::reg_idx_t rt_idx,
  input  cpu_isa_pkg::word_t    rs_val,
  input  cpu_isa_pkg::word_t    rt_val,
  output cpu_pipe_pkg::id_ex_t  id_rec
);

  localparam int SEXT_W = cpu_isa_pkg::WORD_W - cpu_isa_pkg::REG_IDX_W;
  localparam int ZEXT_W = cpu_isa_pkg::WORD_W - cpu_isa_pkg::IMM8_W;

  cpu_isa_pkg::opcode_e opcode;
  logic                 accept;
  logic                 is_alu;
  logic                 is_lw;
  logic                 is_sw;
  logic                 is_lh;
  logic                 is_hlt;

  // Decode only takes a word when execute can take the previous one
  assign instr_ready = stall_n;
  assign accept      = instr_valid && stall_n;

  // Opcode sits in the same bits in both views
  assign opcode = instr.r_fmt.opcode;

  assign is_alu = opcode inside {cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB,
                                 cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_XOR,
                                 cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_SRL};
  assign is_lw  = (opcode == cpu_isa_pkg::OP_LW);
  assign is_sw  = (opcode == cpu_isa_pkg::OP_SW);
  assign is_lh  = opcode inside {cpu_isa_pkg::OP_LLB, cpu_isa_pkg::OP_LHB};
  assign is_hlt = (opcode == cpu_isa_pkg::OP_HLT);

  // Load-half needs the old rd for the merge, SW needs rd as store data
  assign rs_idx = instr.r_fmt.rs;
  assign rt_idx = (is_lh || is_sw) ? instr.r_fmt.rd : instr.r_fmt.rt;

  always_comb begin
    id_rec         = cpu_pipe_pkg::ID_EX_NOP;
    id_rec.valid   = accept;
    id_rec.opcode  = opcode;
    // rd sits in the same bits in both views
    id_rec.rd      = instr.r_fmt.rd;
    id_rec.rs_data = rs_val;
    id_rec.rt_data = rt_val;

    if (is_lh) begin
      id_rec.imm = {{ZEXT_W{1'b0}}, instr.i_fmt.imm};
    end else begin
      // Signed word offset for LW and SW
      id_rec.imm = {{SEXT_W{instr.r_fmt.rt[cpu_isa_pkg::REG_IDX_W-1]}}, instr.r_fmt.rt};
    end

    // Flags only on an accepted word
    id_rec.mem_read  = accept && is_lw;
    id_rec.mem_write = accept && is_sw;
    id_rec.reg_write = accept && (is_alu || is_lw || is_lh);
    id_rec.halt      = accept && is_hlt;
  end

endmodule

//--- source/reg_file.sv
// 16x16 register file: two read ports, one write port, write-through bypass, r0 hardwired to zero
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_isa_pkg::reg_idx_t rs_idx,
  input  cpu_isa_pkg::reg_idx_t rt_idx,
  output cpu_isa_pkg::word_t    rs_val,
  output cpu_isa_pkg::word_t    rt_val,
  input  cpu_pipe_pkg::commit_t wr
);

  cpu_isa_pkg::word_t regs [cpu_isa_pkg::NUM_REGS];

  // Same-cycle write wins, so decode sees the value execute is committing
  function automatic cpu_isa_pkg::word_t read_port(input cpu_isa_pkg::reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wr.valid && (wr.rd == idx)) begin
      return wr.data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && (wr.rd != '0)) begin
      regs[wr.rd] <= wr.data;
    end
  end

  always_comb begin
    rs_val = read_port(rs_idx);
    rt_val = read_port(rt_idx);
  end

endmodule

//--- source/cpu_pipe_pkg.sv
// Pipeline records: ID/EX record, no-op record constant, commit record
package cpu_pipe_pkg;

  // Everything execute needs, captured at the decode edge
  typedef struct packed {
    logic                  valid;
    cpu_isa_pkg::opcode_e  opcode;
    cpu_isa_pkg::reg_idx_t rd;
    // Base address or ALU operand A
    cpu_isa_pkg::word_t    rs_data;
    // ALU operand B, store data, or old rd value for load-half
    cpu_isa_pkg::word_t    rt_data;
    // Sign-extended word offset or zero-extended byte immediate
    cpu_isa_pkg::word_t    imm;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  halt;
  } id_ex_t;

  // Bubble loaded on reset
  localparam id_ex_t ID_EX_NOP = '0;

  // One register write, also reported on the trace port
  typedef struct packed {
    logic                  valid;
    cpu_isa_pkg::reg_idx_t rd;
    cpu_isa_pkg::word_t    data;
  } commit_t;

endpackage

//--- source/cpu_isa_pkg.sv
// Instruction set: field widths, opcode encoding, register index and data word types, instruction word formats
package cpu_isa_pkg;

  localparam int WORD_W    = 16;
  localparam int REG_IDX_W = 4;
  localparam int OPCODE_W  = 4;
  localparam int IMM8_W    = 8;
  localparam int NUM_REGS  = 16;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Unlisted encodings execute as no-ops
  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_XOR = 4'd3,
    OP_SLL = 4'd4,
    OP_SRL = 4'd5,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_LHB = 4'd11,
    OP_HLT = 4'd15
  } opcode_e;

  // Register format, also used by LW and SW with rt as a signed word offset
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
  } r_fmt_t;

  // Byte immediate format for LLB and LHB
  typedef struct packed {
    opcode_e           opcode;
    reg_idx_t          rd;
    logic [IMM8_W-1:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

endpackage
